// ==== Bender.yml ====
package:
  name: ps2_mouse

sources:
  - common/ps2_pkg.sv
  - common/ps2_line_if.sv
  - ps2/ps2_line_sync.sv
  - ps2/ps2_receiver.sv
  - ps2/ps2_transmitter.sv
  - mouse/mouse_packet_fsm.sv
  - logic/ps2_mouse.sv
  - target: simulation
    files:
      - verification/tb_ps2_mouse.sv

// ==== common/ps2_line_if.sv ====
// PS/2 line layer interface
`default_nettype none

interface ps2_line_if;

   // Synchronised device side
   logic clk_fall;
   logic data;

   // Open-drain pull-down requests from the host
   logic clk_low;
   logic data_low;

   // Transmitter owns the bus
   logic tx_active;

   modport sync (output clk_fall, output data);
   modport rx (input clk_fall, input data, input tx_active);
   modport tx (input clk_fall, input data, output clk_low, output data_low,
               output tx_active);
   modport top (input clk_low, input data_low);

endinterface

`default_nettype wire

// ==== common/ps2_pkg.sv ====
// PS/2 mouse host shared definitions
`default_nettype none

package ps2_pkg;

   //////////////////////////////////////////////////
   // Protocol bytes
   //////////////////////////////////////////////////

   // Read Data poll command
   localparam logic [7:0] CMD_READ_DATA = 8'hEB;
   // Acknowledge returned by the mouse
   localparam logic [7:0] RESP_ACK = 8'hFA;

   //////////////////////////////////////////////////
   // Timing limits in clk cycles, 10 MHz clock
   //////////////////////////////////////////////////

   // Clock inhibit ahead of the start bit, 100 us
   localparam logic [15:0] INHIBIT_CYCLES = 16'd1000;
   // Longest gap between device clock falls in a frame
   localparam logic [15:0] BIT_TIMEOUT_CYCLES = 16'd4000;
   // Longest wait for each expected byte, 2 ms
   localparam logic [15:0] RESP_TIMEOUT_CYCLES = 16'd20000;

   // One decoded movement packet
   // Deltas are sign extended from the 9-bit PS/2 form
   typedef struct packed {
      logic        button_l;
      logic        button_m;
      logic        button_r;
      logic        x_overflow;
      logic        y_overflow;
      logic [11:0] dx;
      logic [11:0] dy;
   } mouse_report_t;

endpackage

`default_nettype wire

// ==== list.f ====
common/ps2_pkg.sv
common/ps2_line_if.sv
ps2/ps2_line_sync.sv
ps2/ps2_receiver.sv
ps2/ps2_transmitter.sv
mouse/mouse_packet_fsm.sv
logic/ps2_mouse.sv
verification/tb_ps2_mouse.sv

// ==== logic/ps2_mouse.sv ====
// PS/2 mouse host controller top
`default_nettype none

module ps2_mouse (
   input  logic        clk,
   input  logic        reset,
   input  logic        ps2_clk_in,
   input  logic        ps2_data_in,
   output logic        ps2_clk_low,
   output logic        ps2_data_low,
   output logic        button_l,
   output logic        button_m,
   output logic        button_r,
   output logic        x_overflow,
   output logic        y_overflow,
   output logic [11:0] dx,
   output logic [11:0] dy,
   output logic        report_valid,
   output logic        packet_error
);

   // Line layer shared by sync, receiver and transmitter
   ps2_line_if line ();

   // Receiver to sequencer
   logic [7:0]             rx_byte;
   logic                   rx_valid;
   logic                   rx_error;
   // Sequencer and transmitter handshake
   logic                   tx_send;
   logic [7:0]             tx_byte;
   logic                   tx_busy;
   logic                   tx_done;
   logic                   tx_nack;
   ps2_pkg::mouse_report_t report;

   ps2_line_sync u_line_sync (
      .clk         (clk),
      .reset       (reset),
      .ps2_clk_in  (ps2_clk_in),
      .ps2_data_in (ps2_data_in),
      .line        (line)
   );

   ps2_receiver u_receiver (
      .clk      (clk),
      .reset    (reset),
      .line     (line),
      .rx_byte  (rx_byte),
      .rx_valid (rx_valid),
      .rx_error (rx_error)
   );

   ps2_transmitter u_transmitter (
      .clk     (clk),
      .reset   (reset),
      .line    (line),
      .tx_send (tx_send),
      .tx_byte (tx_byte),
      .tx_busy (tx_busy),
      .tx_done (tx_done),
      .tx_nack (tx_nack)
   );

   mouse_packet_fsm u_packet_fsm (
      .clk          (clk),
      .reset        (reset),
      .rx_byte      (rx_byte),
      .rx_valid     (rx_valid),
      .rx_error     (rx_error),
      .tx_busy      (tx_busy),
      .tx_done      (tx_done),
      .tx_nack      (tx_nack),
      .tx_send      (tx_send),
      .tx_byte      (tx_byte),
      .report       (report),
      .report_valid (report_valid),
      .packet_error (packet_error)
   );

   // Open-drain pull-downs to the pad drivers
   assign ps2_clk_low  = line.clk_low;
   assign ps2_data_low = line.data_low;

   // Report fields out as plain ports
   assign button_l   = report.button_l;
   assign button_m   = report.button_m;
   assign button_r   = report.button_r;
   assign x_overflow = report.x_overflow;
   assign y_overflow = report.y_overflow;
   assign dx         = report.dx;
   assign dy         = report.dy;

endmodule

`default_nettype wire

// ==== mouse/mouse_packet_fsm.sv ====
// Mouse poll and packet sequencer
`default_nettype none

module mouse_packet_fsm (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [7:0]             rx_byte,
   input  logic                   rx_valid,
   input  logic                   rx_error,
   input  logic                   tx_busy,
   input  logic                   tx_done,
   input  logic                   tx_nack,
   output logic                   tx_send,
   output logic [7:0]             tx_byte,
   output ps2_pkg::mouse_report_t report,
   output logic                   report_valid,
   output logic                   packet_error
);

   typedef enum logic [2:0] {
      IDLE,
      WAIT_TX,
      WAIT_ACK,
      BYTE1,
      BYTE2,
      BYTE3
   } state_t;

   state_t      state;
   // Reloaded for each expected byte
   logic [15:0] resp_timer;
   logic        resp_timeout;
   // Byte 1: yovf xovf ysgn xsgn 1 mbtn rbtn lbtn
   logic [7:0]  byte1;
   // Byte 2: x movement
   logic [7:0]  byte2;

   // Only ever poll
   assign tx_byte      = ps2_pkg::CMD_READ_DATA;
   assign resp_timeout = (resp_timer == ps2_pkg::RESP_TIMEOUT_CYCLES - 16'd1);

   //////////////////////////////////////////////////
   // Poll sequence
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= IDLE;
         resp_timer   <= 16'd0;
         tx_send      <= 1'b0;
         report_valid <= 1'b0;
         packet_error <= 1'b0;
         report       <= '0;
      end else begin
         tx_send      <= 1'b0;
         report_valid <= 1'b0;
         packet_error <= 1'b0;
         case (state)
            IDLE: begin
               if (!tx_busy) begin
                  tx_send <= 1'b1;
                  state   <= WAIT_TX;
               end
            end
            WAIT_TX: begin
               // Command goes out, then the ack byte comes back
               if (tx_done) begin
                  resp_timer <= 16'd0;
                  if (tx_nack) begin
                     packet_error <= 1'b1;
                     state        <= IDLE;
                  end else begin
                     state <= WAIT_ACK;
                  end
               end
            end
            WAIT_ACK, BYTE1, BYTE2, BYTE3: begin
               if (rx_error || resp_timeout) begin
                  packet_error <= 1'b1;
                  state        <= IDLE;
               end else if (rx_valid) begin
                  resp_timer <= 16'd0;
                  case (state)
                     WAIT_ACK: begin
                        if (rx_byte == ps2_pkg::RESP_ACK) begin
                           state <= BYTE1;
                        end else begin
                           packet_error <= 1'b1;
                           state        <= IDLE;
                        end
                     end
                     BYTE1: begin
                        // Bit 3 is always set in a valid first byte
                        if (rx_byte[3]) begin
                           state <= BYTE2;
                        end else begin
                           packet_error <= 1'b1;
                           state        <= IDLE;
                        end
                     end
                     BYTE2: state <= BYTE3;
                     BYTE3: begin
                        report.button_l   <= byte1[0];
                        report.button_m   <= byte1[2];
                        report.button_r   <= byte1[1];
                        report.x_overflow <= byte1[6];
                        report.y_overflow <= byte1[7];
                        // Sign bits live in byte 1
                        report.dx         <= {{4{byte1[4]}}, byte2};
                        report.dy         <= {{4{byte1[5]}}, rx_byte};
                        report_valid      <= 1'b1;
                        state             <= IDLE;
                     end
                     default: state <= IDLE;
                  endcase
               end else begin
                  resp_timer <= resp_timer + 16'd1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Packet bytes held until the third arrives
   always_ff @(posedge clk) begin
      if (rx_valid && state == BYTE1) begin
         byte1 <= rx_byte;
      end
      if (rx_valid && state == BYTE2) begin
         byte2 <= rx_byte;
      end
   end

endmodule

`default_nettype wire

// ==== ps2/ps2_line_sync.sv ====
// PS/2 input synchroniser
`default_nettype none

module ps2_line_sync (
   input  logic     clk,
   input  logic     reset,
   input  logic     ps2_clk_in,
   input  logic     ps2_data_in,
   ps2_line_if.sync line
);

   // Two stage synchronisers, idle level is high
   logic [1:0] clk_sync;
   logic [1:0] data_sync;
   // Previous synchronised clock level
   logic       clk_prev;
   logic       fall_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
         fall_q    <= 1'b0;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk_in};
         data_sync <= {data_sync[0], ps2_data_in};
         clk_prev  <= clk_sync[1];
         // High to low on the synchronised clock
         fall_q    <= clk_prev & ~clk_sync[1];
      end
   end

   // Pulse lands 3 cycles after the pin edge
   assign line.clk_fall = fall_q;
   // Data is stable for many cycles around the fall
   assign line.data     = data_sync[1];

endmodule

`default_nettype wire

// ==== ps2/ps2_receiver.sv ====
// PS/2 device-to-host frame receiver
`default_nettype none

module ps2_receiver (
   input  logic       clk,
   input  logic       reset,
   ps2_line_if.rx     line,
   output logic [7:0] rx_byte,
   output logic       rx_valid,
   output logic       rx_error
);

   // Bits taken so far in the current frame, 0 means idle
   logic [3:0]  bit_cnt;
   // Start, data LSB first, parity
   logic [9:0]  frame;
   // Cycles since the last device clock fall
   logic [15:0] idle_cnt;
   logic        in_frame;
   logic        timed_out;
   logic        frame_ok;
   logic        take_bit;

   assign take_bit  = line.clk_fall && !line.tx_active;
   assign in_frame  = (bit_cnt != 4'd0);
   assign timed_out = in_frame && (idle_cnt == ps2_pkg::BIT_TIMEOUT_CYCLES - 16'd1);

   // Start low, odd parity over data and parity, stop high
   assign frame_ok = !frame[0] && (^frame[9:1]) && line.data;

   //////////////////////////////////////////////////
   // Bit counter and status pulses
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt  <= 4'd0;
         idle_cnt <= 16'd0;
         rx_valid <= 1'b0;
         rx_error <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         rx_error <= 1'b0;
         if (line.tx_active) begin
            // Host owns the bus, drop any partial frame
            bit_cnt  <= 4'd0;
            idle_cnt <= 16'd0;
         end else if (line.clk_fall) begin
            idle_cnt <= 16'd0;
            if (bit_cnt == 4'd10) begin
               // Stop bit is on the line now
               bit_cnt  <= 4'd0;
               rx_valid <= frame_ok;
               rx_error <= !frame_ok;
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end else if (timed_out) begin
            // Device stalled mid-frame
            bit_cnt  <= 4'd0;
            idle_cnt <= 16'd0;
            rx_error <= 1'b1;
         end else if (in_frame) begin
            idle_cnt <= idle_cnt + 16'd1;
         end
      end
   end

   // Shift register and received byte
   always_ff @(posedge clk) begin
      if (take_bit && bit_cnt != 4'd10) begin
         frame <= {line.data, frame[9:1]};
      end
      if (take_bit && bit_cnt == 4'd10) begin
         rx_byte <= frame[8:1];
      end
   end

endmodule

`default_nettype wire

// ==== ps2/ps2_transmitter.sv ====
// PS/2 host-to-device command transmitter
`default_nettype none

module ps2_transmitter (
   input  logic       clk,
   input  logic       reset,
   ps2_line_if.tx     line,
   input  logic       tx_send,
   input  logic [7:0] tx_byte,
   output logic       tx_busy,
   output logic       tx_done,
   output logic       tx_nack
);

   // ACK is the single cycle that reports the result
   typedef enum logic [2:0] {
      IDLE,
      INHIBIT,
      START,
      SHIFT,
      STOP,
      ACK
   } state_t;

   state_t      state;
   // Inhibit interval, then bit timeout
   logic [15:0] cnt;
   // Parity above the data byte, bit 0 is on the line
   logic [8:0]  frame;
   // Index of the bit being presented
   logic [3:0]  bit_idx;
   logic        can_start;
   logic        inhibit_end;
   logic        bit_timeout;

   assign can_start   = (state == IDLE || state == ACK) && tx_send;
   assign inhibit_end = (cnt == ps2_pkg::INHIBIT_CYCLES - 16'd1);
   assign bit_timeout = (cnt == ps2_pkg::BIT_TIMEOUT_CYCLES - 16'd1);

   //////////////////////////////////////////////////
   // Transfer sequencing
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= IDLE;
         cnt     <= 16'd0;
         bit_idx <= 4'd0;
         tx_nack <= 1'b0;
      end else begin
         case (state)
            IDLE, ACK: begin
               cnt   <= 16'd0;
               state <= can_start ? INHIBIT : IDLE;
            end
            INHIBIT: begin
               // Clock held low, then request to send
               if (inhibit_end) begin
                  cnt   <= 16'd0;
                  state <= START;
               end else begin
                  cnt <= cnt + 16'd1;
               end
            end
            START, SHIFT, STOP: begin
               if (line.clk_fall) begin
                  cnt <= 16'd0;
                  if (state == START) begin
                     // Device began clocking, present bit 0
                     bit_idx <= 4'd0;
                     state   <= SHIFT;
                  end else if (state == SHIFT) begin
                     if (bit_idx == 4'd8) begin
                        // Parity done, release for stop bit
                        state <= STOP;
                     end else begin
                        bit_idx <= bit_idx + 4'd1;
                     end
                  end else begin
                     // Device pulls data low to acknowledge
                     tx_nack <= line.data;
                     state   <= ACK;
                  end
               end else if (bit_timeout) begin
                  tx_nack <= 1'b1;
                  state   <= ACK;
               end else begin
                  cnt <= cnt + 16'd1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Latch command with odd parity, shift on each fall
   always_ff @(posedge clk) begin
      if (can_start) begin
         frame <= {~^tx_byte, tx_byte};
      end else if (state == SHIFT && line.clk_fall && bit_idx != 4'd8) begin
         frame <= {1'b1, frame[8:1]};
      end
   end

   assign tx_busy        = (state != IDLE) && (state != ACK);
   assign tx_done        = (state == ACK);
   assign line.tx_active = tx_busy;
   assign line.clk_low   = (state == INHIBIT);
   // Start bit low, then data and parity
   assign line.data_low  = (state == START) || ((state == SHIFT) && !frame[0]);

endmodule

`default_nettype wire

// ==== verification/tb_ps2_mouse.sv ====
// PS/2 mouse host controller testbench
`default_nettype none

module tb_ps2_mouse;

   timeunit 1ns;
   timeprecision 1ps;

   // Device clock half period of 4 us in clk cycles
   localparam int HALF_BIT = 40;
   localparam int QUARTER_BIT = 20;
   // Random good packets plus one poll per fault case and recovery
   localparam int NUM_GOOD = 20;
   localparam int NUM_POLLS = NUM_GOOD + 7;

   logic        clk;
   logic        reset;
   logic        ps2_clk_in;
   logic        ps2_data_in;
   logic        ps2_clk_low;
   logic        ps2_data_low;
   logic        button_l;
   logic        button_m;
   logic        button_r;
   logic        x_overflow;
   logic        y_overflow;
   logic [11:0] dx;
   logic [11:0] dy;
   logic        report_valid;
   logic        packet_error;

   // Mouse model pull-downs
   logic        dev_clk_low;
   logic        dev_data_low;
   logic [31:0] lfsr;
   logic        quiet_phase;
   int          error_count;
   int          report_count;
   int          fail_count;
   int          pending_errors;
   int          low_run;
   int          last_inhibit;
   // Buttons, overflow, dx, dy in port order
   logic [28:0] expected_q[$];
   logic [28:0] expected_report;
   logic [28:0] actual_report;

   ps2_mouse i_dut (
      .clk          (clk),
      .reset        (reset),
      .ps2_clk_in   (ps2_clk_in),
      .ps2_data_in  (ps2_data_in),
      .ps2_clk_low  (ps2_clk_low),
      .ps2_data_low (ps2_data_low),
      .button_l     (button_l),
      .button_m     (button_m),
      .button_r     (button_r),
      .x_overflow   (x_overflow),
      .y_overflow   (y_overflow),
      .dx           (dx),
      .dy           (dy),
      .report_valid (report_valid),
      .packet_error (packet_error)
   );

   // Open-drain wired AND of host and mouse
   assign ps2_clk_in    = ~(ps2_clk_low | dev_clk_low);
   assign ps2_data_in   = ~(ps2_data_low | dev_data_low);
   assign actual_report = {button_l, button_m, button_r, x_overflow, y_overflow, dx, dy};

   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic report_error(input string msg);
      error_count++;
      $display("Error at %0d ns: %s", $time, msg);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // Taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit
   task automatic take_random_byte(output logic [7:0] value);
      value = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr  = lfsr_step(lfsr);
         value = {value[6:0], lfsr[0]};
      end
   endtask

   // Movement is a 9-bit signed value with the sign bit in byte 1
   function automatic logic [28:0] decode_packet(input logic [7:0] b1, b2, b3);
      int x_move;
      int y_move;
      logic [31:0] x_bits;
      logic [31:0] y_bits;
      x_move = b1[4] ? int'(b2) - 256 : int'(b2);
      y_move = b1[5] ? int'(b3) - 256 : int'(b3);
      x_bits = x_move;
      y_bits = y_move;
      return {b1[0], b1[2], b1[1], b1[6], b1[7], x_bits[11:0], y_bits[11:0]};
   endfunction

   //////////////////////////////////////////////////
   // Mouse model
   //////////////////////////////////////////////////

   // Host request to send and 10 clocked bits before the ack pulse
   task automatic receive_command(input logic give_ack);
      logic [9:0] bits;
      while (!ps2_clk_low) @(negedge clk);
      while (ps2_clk_low) @(negedge clk);
      assert (ps2_data_low) else report_error("no start bit after clock inhibit");
      wait_cycles(HALF_BIT);
      assert (last_inhibit >= ps2_pkg::INHIBIT_CYCLES)
         else report_error($sformatf("clock inhibit only %0d cycles", last_inhibit));
      for (int i = 0; i < 10; i++) begin
         dev_clk_low = 1'b1;
         wait_cycles(HALF_BIT);
         dev_clk_low = 1'b0;
         wait_cycles(QUARTER_BIT);
         // Sample in the middle of the high phase
         bits[i] = ps2_data_in;
         wait_cycles(QUARTER_BIT);
      end
      assert (bits[7:0] == ps2_pkg::CMD_READ_DATA)
         else report_error($sformatf("command %h, expected %h", bits[7:0],
                                     ps2_pkg::CMD_READ_DATA));
      assert (^bits[8:0]) else report_error("command parity is not odd");
      assert (bits[9]) else report_error("command stop bit is low");
      dev_data_low = give_ack;
      dev_clk_low  = 1'b1;
      wait_cycles(HALF_BIT);
      dev_clk_low  = 1'b0;
      wait_cycles(QUARTER_BIT);
      dev_data_low = 1'b0;
   endtask

   // Start, data LSB first, odd parity unless corrupted, stop
   task automatic send_frame(input logic [7:0] value, input logic bad_parity);
      logic [10:0] bits;
      bits = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
      for (int i = 0; i < 11; i++) begin
         dev_data_low = ~bits[i];
         wait_cycles(QUARTER_BIT);
         dev_clk_low = 1'b1;
         wait_cycles(HALF_BIT);
         dev_clk_low = 1'b0;
         wait_cycles(QUARTER_BIT);
      end
      dev_data_low = 1'b0;
      wait_cycles(100);
   endtask

   // Poll answered with a random packet and optional bad parity on byte 3
   task automatic answer_poll(input logic bad_parity);
      logic [7:0] b1;
      logic [7:0] b2;
      logic [7:0] b3;
      receive_command(1'b1);
      send_frame(ps2_pkg::RESP_ACK, 1'b0);
      take_random_byte(b1);
      take_random_byte(b2);
      take_random_byte(b3);
      b1[3] = 1'b1;
      if (bad_parity) begin
         pending_errors++;
      end else begin
         expected_q.push_back(decode_packet(b1, b2, b3));
      end
      send_frame(b1, 1'b0);
      send_frame(b2, 1'b0);
      send_frame(b3, bad_parity);
   endtask

   //////////////////////////////////////////////////
   // Checkers
   //////////////////////////////////////////////////

   // Pulse lengths of the host clock inhibit
   always @(posedge clk) begin
      if (reset) begin
         low_run      <= 0;
         last_inhibit <= 0;
      end else if (ps2_clk_low) begin
         low_run <= low_run + 1;
      end else if (low_run != 0) begin
         last_inhibit <= low_run;
         low_run      <= 0;
      end
   end

   // Idle lines and a cleared report until the first poll
   quiet_until_poll: assert property (@(posedge clk) quiet_phase |->
      (!(ps2_clk_low || ps2_data_low || report_valid || packet_error)
       && (actual_report == '0)))
      else report_error("output active before the first poll");

   one_outcome: assert property (@(posedge clk) !reset |-> !(report_valid && packet_error))
      else report_error("report_valid and packet_error together");

   always @(negedge clk) begin
      if (!reset && report_valid) begin
         report_count++;
         assert (expected_q.size() != 0) else report_error("report_valid with none expected");
         if (expected_q.size() != 0) begin
            expected_report = expected_q.pop_front();
            assert (actual_report == expected_report)
               else report_error($sformatf("report %h, expected %h", actual_report,
                                           expected_report));
         end
      end
      if (!reset && packet_error) begin
         fail_count++;
         assert (pending_errors > 0) else report_error("packet_error with none expected");
         if (pending_errors > 0) begin
            pending_errors--;
         end
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial begin
      clk            = 1'b0;
      reset          = 1'b1;
      dev_clk_low    = 1'b0;
      dev_data_low   = 1'b0;
      lfsr           = 32'h6b4fbf61;
      quiet_phase    = 1'b0;
      error_count    = 0;
      report_count   = 0;
      fail_count     = 0;
      pending_errors = 0;
      @(negedge clk);
      quiet_phase = 1'b1;
      wait_cycles(9);
      reset       = 1'b0;
      // First poll starts with the clock inhibit
      while (!ps2_clk_low) @(negedge clk);
      quiet_phase = 1'b0;

      for (int n = 0; n < NUM_GOOD; n++) begin
         answer_poll(1'b0);
      end
      // Corrupted byte followed by a recovery poll
      answer_poll(1'b1);
      answer_poll(1'b0);
      // Device NACK on the command
      pending_errors++;
      receive_command(1'b0);
      // Wrong acknowledge byte
      pending_errors++;
      receive_command(1'b1);
      send_frame(8'hFE, 1'b0);
      // First byte without bit 3
      pending_errors++;
      receive_command(1'b1);
      send_frame(ps2_pkg::RESP_ACK, 1'b0);
      send_frame(8'h01, 1'b0);
      // Mouse silent after the acknowledge
      pending_errors++;
      receive_command(1'b1);
      send_frame(ps2_pkg::RESP_ACK, 1'b0);
      answer_poll(1'b0);

      while (expected_q.size() != 0 || pending_errors != 0) @(negedge clk);
      wait_cycles(10);
      assert (report_count == NUM_GOOD + 2)
         else report_error($sformatf("%0d reports, expected %0d", report_count, NUM_GOOD + 2));
      $display("Reports %0d, packet errors %0d, check errors %0d",
               report_count, fail_count, error_count);
      if (error_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // 2 ms per poll plus margin
   initial begin
      #(NUM_POLLS * 2_000_000 + 5_000_000);
      $display("Watchdog expired before the test sequence finished");
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
